// File: common/mpmc_consts.svh
`ifndef MPMC_CONSTS_SVH
`define MPMC_CONSTS_SVH

// ====================
// Controller sizing
// ====================

// Number of requesting ports and the width of a port tag
`define MPMC_NPORTS 2
`define MPMC_PORT_W 1

// Word address, data word and burst length widths
`define MPMC_ADDR_W 10
`define MPMC_DATA_W 32
`define MPMC_LEN_W 8

// Cycles from a read address at the array to its data on resp
`define MPMC_RD_LATENCY 3

// Response credits per port and the counter width that holds them
`define MPMC_RESP_CREDITS 4
`define MPMC_CRED_W 3

`endif

// File: common/mpmc_cmd_pkg.sv
// Types that cross the controller boundary on the request and response channels
package mpmc_cmd_pkg;

`include "mpmc_consts.svh"

	// ====================
	// Opcodes
	// ====================

	// One bit is enough while only reads and single-word writes exist
	typedef enum logic [0:0] {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mpmc_op_t;

	// ====================
	// Request channel
	// ====================

	// A read asks for burst_len + 1 beats starting at addr
	// A write stores wdata at addr and ignores burst_len
	typedef struct packed {
		logic                      valid;
		mpmc_op_t                  op;
		logic [`MPMC_ADDR_W-1:0]   addr;
		logic [`MPMC_LEN_W-1:0]    burst_len;
		logic [`MPMC_DATA_W-1:0]   wdata;
	} mpmc_req_t;

	// ====================
	// Response channel
	// ====================

	// Shared by all ports, the port field says who owns the beat
	typedef struct packed {
		logic                      valid;
		logic [`MPMC_PORT_W-1:0]   port;
		logic                      last;
		logic [`MPMC_DATA_W-1:0]   data;
	} mpmc_resp_t;

endpackage

// File: common/mpmc_ctrl_pkg.sv
// Types used only inside the controller
package mpmc_ctrl_pkg;

`include "mpmc_consts.svh"

	// Command sequencer states
	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		READ_DATA0,
		READ_DATA,
		DONE
	} mpmc_state_t;

	// Arbiter output, a copy of the winning slot
	typedef struct packed {
		logic                      valid;
		logic [`MPMC_PORT_W-1:0]   port;
		mpmc_cmd_pkg::mpmc_req_t   cmd;
	} mpmc_grant_t;

	// One access to the storage array, last and port ride along with reads
	typedef struct packed {
		logic                      valid;
		logic                      write;
		logic                      last;
		logic [`MPMC_PORT_W-1:0]   port;
		logic [`MPMC_ADDR_W-1:0]   addr;
		logic [`MPMC_DATA_W-1:0]   wdata;
	} mpmc_mem_cmd_t;

endpackage

// File: source/mpmc_port_arbiter.sv
`include "mpmc_consts.svh"

// Holds one command per port and offers them to the sequencer in round-robin order
module mpmc_port_arbiter (
	input  logic                                              clk,
	input  logic                                              rst,
	input  mpmc_cmd_pkg::mpmc_req_t [`MPMC_NPORTS-1:0]        req,
	input  logic                                              take,
	output logic [`MPMC_NPORTS-1:0]                           req_credit,
	output mpmc_ctrl_pkg::mpmc_grant_t                        grant
);

	// ====================
	// Command slots
	// ====================

	logic [`MPMC_NPORTS-1:0]    slot_full;
	mpmc_cmd_pkg::mpmc_req_t    slot_cmd [`MPMC_NPORTS];

	// Port with the highest priority this cycle
	logic [`MPMC_PORT_W-1:0]    rr_ptr;
	logic [`MPMC_PORT_W-1:0]    sel_port;
	logic                       sel_found;
	int unsigned                sel_idx;

	// A slot fills when its port sends and empties when the sequencer takes it
	// The two never coincide because the port has no credit while its slot is full
	always_ff @(posedge clk) begin
		if (rst) begin
			slot_full  <= '0;
			req_credit <= '0;
			rr_ptr     <= '0;
		end else begin
			// Credit goes back one cycle after the slot is freed
			req_credit <= '0;
			for (int p = 0; p < `MPMC_NPORTS; p++) begin
				if (take && grant.port == `MPMC_PORT_W'(p)) begin
					slot_full[p]  <= 1'b0;
					req_credit[p] <= 1'b1;
				end else if (req[p].valid) begin
					slot_full[p] <= 1'b1;
				end
			end
			// Priority moves just past the winner
			if (take)
				rr_ptr <= `MPMC_PORT_W'((int'(grant.port) + 1) % `MPMC_NPORTS);
		end
	end

	// Slot payload needs no reset, slot_full says when it is meaningful
	always_ff @(posedge clk) begin
		for (int p = 0; p < `MPMC_NPORTS; p++) begin
			if (req[p].valid)
				slot_cmd[p] <= req[p];
		end
	end

	// ====================
	// Round-robin pick
	// ====================

	// Walk the ports starting at rr_ptr and stop at the first full slot
	always_comb begin
		sel_found = 1'b0;
		sel_port  = rr_ptr;
		sel_idx   = 0;
		for (int i = 0; i < `MPMC_NPORTS; i++) begin
			sel_idx = (int'(rr_ptr) + i) % `MPMC_NPORTS;
			if (!sel_found && slot_full[sel_idx]) begin
				sel_found = 1'b1;
				sel_port  = `MPMC_PORT_W'(sel_idx);
			end
		end
	end

	assign grant.valid = sel_found;
	assign grant.port  = sel_port;
	assign grant.cmd   = slot_cmd[sel_port];

	// The port side must honour its single request credit
	for (genvar p = 0; p < `MPMC_NPORTS; p++) begin : g_slot_chk
		a_no_overrun: assert property (@(posedge clk) disable iff (rst)
			req[p].valid |-> !slot_full[p])
			else $error("port %0d sent a command while its slot was full", p);
	end

endmodule

// File: mpmc_engine/mpmc_state_machine.sv
`include "mpmc_consts.svh"

// Sequences one command at a time and issues read beats under response credit
module mpmc_state_machine (
	input  logic                                clk,
	input  logic                                rst,
	input  mpmc_ctrl_pkg::mpmc_grant_t          grant,
	output logic                                take,
	input  logic [`MPMC_NPORTS-1:0]             resp_credit,
	input  logic                                burst_done,
	output mpmc_ctrl_pkg::mpmc_state_t          state,
	output logic [`MPMC_LEN_W-1:0]              burst_len,
	output mpmc_ctrl_pkg::mpmc_mem_cmd_t        mem_cmd
);

	// ====================
	// Command context
	// ====================

	logic [`MPMC_PORT_W-1:0]    cur_port;
	logic [`MPMC_ADDR_W-1:0]    cur_addr;
	logic [`MPMC_DATA_W-1:0]    cur_wdata;
	// One bit wider than burst_len so a 256 beat burst still fits
	logic [`MPMC_LEN_W:0]       issue_left;

	// Response credits held per port
	logic [`MPMC_CRED_W-1:0]    cred [`MPMC_NPORTS];
	logic [`MPMC_NPORTS-1:0]    issue_hit;
	logic                       read_phase;
	logic                       issue;

	// The sequencer only accepts work when idle
	assign take = (state == mpmc_ctrl_pkg::IDLE) && grant.valid;

	// Beats go out in both read states as long as addresses remain and credit exists
	assign read_phase = (state == mpmc_ctrl_pkg::READ_DATA0) ||
		(state == mpmc_ctrl_pkg::READ_DATA);
	assign issue = read_phase && (issue_left != '0) && (cred[cur_port] != '0);

	always_comb begin
		for (int p = 0; p < `MPMC_NPORTS; p++)
			issue_hit[p] = issue && (cur_port == `MPMC_PORT_W'(p));
	end

	// ====================
	// Sequencer
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= mpmc_ctrl_pkg::IDLE;
			issue_left <= '0;
		end else begin
			case (state)
				mpmc_ctrl_pkg::IDLE:
					if (take) begin
						if (grant.cmd.op == mpmc_cmd_pkg::OP_WRITE)
							state <= mpmc_ctrl_pkg::WRITE;
						else
							state <= mpmc_ctrl_pkg::READ_DATA0;
						issue_left <= {1'b0, grant.cmd.burst_len} + 1'b1;
					end
				// The array commits the word at the end of this cycle
				mpmc_ctrl_pkg::WRITE:
					state <= mpmc_ctrl_pkg::IDLE;
				mpmc_ctrl_pkg::READ_DATA0:
					state <= mpmc_ctrl_pkg::READ_DATA;
				// Stay until the last beat has come back from the array
				mpmc_ctrl_pkg::READ_DATA:
					if (burst_done)
						state <= mpmc_ctrl_pkg::DONE;
				default:
					state <= mpmc_ctrl_pkg::IDLE;
			endcase
			if (issue)
				issue_left <= issue_left - 1'b1;
		end
	end

	// Command context is captured when the grant is taken
	always_ff @(posedge clk) begin
		if (take) begin
			cur_port  <= grant.port;
			cur_addr  <= grant.cmd.addr;
			cur_wdata <= grant.cmd.wdata;
			burst_len <= grant.cmd.burst_len;
		end else if (issue) begin
			// Wraps at the top of the address space by width
			cur_addr <= cur_addr + 1'b1;
		end
	end

	// Issue spends a credit and a pulse from the port gives one back
	always_ff @(posedge clk) begin
		for (int p = 0; p < `MPMC_NPORTS; p++) begin
			if (rst)
				cred[p] <= `MPMC_CRED_W'(`MPMC_RESP_CREDITS);
			else if (issue_hit[p] && !resp_credit[p])
				cred[p] <= cred[p] - 1'b1;
			else if (!issue_hit[p] && resp_credit[p])
				cred[p] <= cred[p] + 1'b1;
		end
	end

	// ====================
	// Array command
	// ====================

	assign mem_cmd.valid = issue || (state == mpmc_ctrl_pkg::WRITE);
	assign mem_cmd.write = (state == mpmc_ctrl_pkg::WRITE);
	assign mem_cmd.last  = issue && (issue_left == 1);
	assign mem_cmd.port  = cur_port;
	assign mem_cmd.addr  = cur_addr;
	assign mem_cmd.wdata = cur_wdata;

	// A beat issued without credit would wrap an empty counter instead of leaving it at zero
	// A port returning more credits than beats it was sent would break the upper bound
	for (genvar p = 0; p < `MPMC_NPORTS; p++) begin : g_cred_chk
		a_read_has_credit: assert property (@(posedge clk) disable iff (rst)
			(cred[p] == '0 && !resp_credit[p]) |=> (cred[p] == '0))
			else $error("read beat issued to port %0d without credit", p);
		a_cred_max: assert property (@(posedge clk) disable iff (rst)
			cred[p] <= `MPMC_CRED_W'(`MPMC_RESP_CREDITS))
			else $error("port %0d credit counter overflowed", p);
	end

endmodule

// File: mpmc_engine/mpmc_resp_burst_cnt.sv
`include "mpmc_consts.svh"

// Counts read beats coming back from the array and flags the final one
module mpmc_resp_burst_cnt (
	input  logic                                clk,
	input  mpmc_ctrl_pkg::mpmc_state_t          state,
	input  logic                                valid,
	input  logic [`MPMC_LEN_W-1:0]              burst_len,
	output logic                                burst_done
);

	// Wide enough to reach burst_len + 1 for the longest burst
	logic [`MPMC_LEN_W:0]   burst_cnt;
	// Set while beats of the current burst are still expected
	logic                   on;

	// Cleared whenever the sequencer is idle
	always_ff @(posedge clk) begin
		if (state == mpmc_ctrl_pkg::IDLE) begin
			burst_cnt <= '0;
			on        <= 1'b0;
		end else begin
			// Arm once per read, beats cannot return before this edge
			if (state == mpmc_ctrl_pkg::READ_DATA0)
				on <= 1'b1;
			if (valid && on) begin
				burst_cnt <= burst_cnt + 1'b1;
				// Final beat seen, stop counting
				if (burst_cnt == {1'b0, burst_len})
					on <= 1'b0;
			end
		end
	end

	// High in the cycle the last beat is on the response channel
	assign burst_done = valid && on && (burst_cnt == {1'b0, burst_len});

	// A beat that shows up while the counter is not armed would push the count
	// past burst_len + 1 or come before the burst started
	a_cnt_bound: assert property (@(posedge clk)
		valid |-> on)
		else $error("response beat with no burst armed, count %0d length %0d",
			burst_cnt, burst_len);

endmodule

// File: source/mpmc_mem_array.sv
`include "mpmc_consts.svh"

// Word-wide storage with a fixed read latency
module mpmc_mem_array (
	input  logic                                clk,
	input  mpmc_ctrl_pkg::mpmc_mem_cmd_t        mem_cmd,
	output mpmc_cmd_pkg::mpmc_resp_t            resp
);

	// ====================
	// Storage
	// ====================

	logic [`MPMC_DATA_W-1:0]    mem [2**`MPMC_ADDR_W];

	// Writes land at the edge closing the write cycle
	always_ff @(posedge clk) begin
		if (mem_cmd.valid && mem_cmd.write)
			mem[mem_cmd.addr] <= mem_cmd.wdata;
	end

	// ====================
	// Read pipeline
	// ====================

	// One stage per cycle of latency, each can hold a beat in flight
	mpmc_cmd_pkg::mpmc_resp_t   pipe [`MPMC_RD_LATENCY];
	logic                       rd;

	assign rd = mem_cmd.valid && !mem_cmd.write;

	// Stage 0 reads the array, port and last are tagged here
	// The valid bits flush to zero while the sequencer sits in IDLE during reset
	always_ff @(posedge clk) begin
		pipe[0].valid <= rd;
		pipe[0].port  <= mem_cmd.port;
		pipe[0].last  <= mem_cmd.last && rd;
		pipe[0].data  <= mem[mem_cmd.addr];
	end

	// Remaining stages only delay the beat
	for (genvar s = 1; s < `MPMC_RD_LATENCY; s++) begin : g_stage
		always_ff @(posedge clk) begin
			pipe[s] <= pipe[s-1];
		end
	end

	assign resp = pipe[`MPMC_RD_LATENCY-1];

endmodule

// File: source/mpmc_top.sv
`include "mpmc_consts.svh"

// Two-port burst memory controller
module mpmc_top (
	input  logic                                              clk,
	input  logic                                              rst,
	input  mpmc_cmd_pkg::mpmc_req_t [`MPMC_NPORTS-1:0]        req,
	output logic [`MPMC_NPORTS-1:0]                           req_credit,
	output mpmc_cmd_pkg::mpmc_resp_t                          resp,
	input  logic [`MPMC_NPORTS-1:0]                           resp_credit
);

	// ====================
	// Internal wiring
	// ====================

	mpmc_ctrl_pkg::mpmc_grant_t     grant;
	logic                           take;
	mpmc_ctrl_pkg::mpmc_state_t     state;
	logic [`MPMC_LEN_W-1:0]         burst_len;
	logic                           burst_done;
	mpmc_ctrl_pkg::mpmc_mem_cmd_t   mem_cmd;

	// Port slots and round-robin choice
	mpmc_port_arbiter i_arbiter (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.take       (take),
		.req_credit (req_credit),
		.grant      (grant)
	);

	// Command sequencer and response credit keeper
	mpmc_state_machine i_state_machine (
		.clk         (clk),
		.rst         (rst),
		.grant       (grant),
		.take        (take),
		.resp_credit (resp_credit),
		.burst_done  (burst_done),
		.state       (state),
		.burst_len   (burst_len),
		.mem_cmd     (mem_cmd)
	);

	// Watches the shared response channel for the end of the burst
	mpmc_resp_burst_cnt i_burst_cnt (
		.clk        (clk),
		.state      (state),
		.valid      (resp.valid),
		.burst_len  (burst_len),
		.burst_done (burst_done)
	);

	// Storage and fixed-latency read return
	mpmc_mem_array i_mem_array (
		.clk     (clk),
		.mem_cmd (mem_cmd),
		.resp    (resp)
	);

endmodule

// File: bench/mpmc_tb.sv
`include "mpmc_consts.svh"

// Drives both request ports and checks every response beat against a shadow memory
module mpmc_tb;

	localparam int NP = `MPMC_NPORTS;
	localparam int DEPTH = 2 ** `MPMC_ADDR_W;
	localparam int WAIT_LIMIT = 4000;

	logic                                   clk;
	logic                                   rst;
	mpmc_cmd_pkg::mpmc_req_t [NP-1:0]       req;
	logic [NP-1:0]                          req_credit;
	mpmc_cmd_pkg::mpmc_resp_t               resp;
	logic [NP-1:0]                          resp_credit;

	// ====================
	// Model state
	// ====================

	logic [`MPMC_DATA_W-1:0]    shadow [DEPTH];
	// Expected beats per port with the last flag in the top bit
	logic [`MPMC_DATA_W:0]      exp_q [NP][$];
	logic [`MPMC_DATA_W:0]      mon_beat;

	// Request credits the port holds right now
	int    req_cred [NP];
	int    cmd_sent [NP];
	int    cred_pulses [NP];
	// Response beats seen and response credits handed back
	int    delivered [NP];
	int    returned [NP];
	int    owed [NP];
	bit    hold_cred [NP];

	int          mismatches;
	int          protocol_errs;
	int          timeouts;
	bit          aborted;
	bit          checking;
	logic [31:0] rng;
	logic [31:0] cred_rng;

	mpmc_top i_dut (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.req_credit  (req_credit),
		.resp        (resp),
		.resp_credit (resp_credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Beat idx of a burst of len + 1 words whose addresses wrap at the top of the space
	function automatic logic [`MPMC_DATA_W:0] expected_beat(input int unsigned start,
		input int unsigned idx, input int unsigned len);
		int unsigned a;
		a = (start + idx) % DEPTH;
		return {idx == len, shadow[a]};
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		aborted = 1'b1;
		$display("timeout: %s did not finish within %0d cycles", what, WAIT_LIMIT);
	endtask

	// Waits for a request credit and then holds valid for exactly one cycle
	task automatic send_cmd(input int p, input mpmc_cmd_pkg::mpmc_op_t op,
		input int unsigned addr, input int unsigned len, input logic [31:0] wdata);
		int waited;
		waited = 0;
		if (aborted)
			return;
		@(negedge clk);
		while (req_cred[p] == 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (req_cred[p] == 0) begin
			report_timeout($sformatf("request credit on port %0d", p));
			return;
		end
		req[p].valid     = 1'b1;
		req[p].op        = op;
		req[p].addr      = `MPMC_ADDR_W'(addr);
		req[p].burst_len = `MPMC_LEN_W'(len);
		req[p].wdata     = wdata;
		req_cred[p]--;
		cmd_sent[p]++;
		if (op == mpmc_cmd_pkg::OP_WRITE)
			shadow[addr % DEPTH] = wdata;
		else
			for (int unsigned i = 0; i <= len; i++)
				exp_q[p].push_back(expected_beat(addr, i, len));
		@(negedge clk);
		req[p] = '0;
	endtask

	task automatic send_reads(input int p, input int n);
		for (int i = 0; i < n; i++)
			send_cmd(p, mpmc_cmd_pkg::OP_READ, next_rand() % DEPTH, next_rand() % 16, '0);
	endtask

	// Everything sent has been answered and every response credit went back
	function automatic bit drained();
		for (int p = 0; p < NP; p++)
			if (exp_q[p].size() != 0 || cred_pulses[p] != cmd_sent[p] ||
				returned[p] != delivered[p])
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic wait_drain(input string what);
		int waited;
		waited = 0;
		if (aborted)
			return;
		while (!drained() && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!drained())
			report_timeout(what);
	endtask

	task automatic wait_ahead(input int p, input int n);
		int waited;
		waited = 0;
		if (aborted)
			return;
		while (delivered[p] - returned[p] < n && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (delivered[p] - returned[p] < n)
			report_timeout($sformatf("credit-limited beats on port %0d", p));
	endtask

	// ====================
	// Response side
	// ====================

	// Compare process that samples every DUT output at the rising edge
	always @(posedge clk) begin
		if (checking) begin
			for (int p = 0; p < NP; p++) begin
				if (req_credit[p]) begin
					cred_pulses[p]++;
					req_cred[p]++;
					if (cred_pulses[p] > cmd_sent[p]) begin
						protocol_errs++;
						$display("port %0d got a request credit with no command accepted", p);
					end
				end
				if (resp_credit[p])
					returned[p]++;
			end
			if (resp.valid) begin
				if (exp_q[resp.port].size() == 0) begin
					protocol_errs++;
					$display("port %0d got a response beat it never asked for", resp.port);
				end else begin
					mon_beat = exp_q[resp.port].pop_front();
					check_value("resp.data", resp.data, mon_beat[`MPMC_DATA_W-1:0]);
					check_value("resp.last", resp.last, mon_beat[`MPMC_DATA_W]);
				end
				delivered[resp.port]++;
				owed[resp.port]++;
			end
			for (int p = 0; p < NP; p++)
				if (delivered[p] - returned[p] > `MPMC_RESP_CREDITS) begin
					protocol_errs++;
					$display("port %0d has more beats delivered than response credits allow", p);
				end
		end
	end

	// Hands response credits back with random gaps unless a port is held
	always @(negedge clk) begin
		if (checking) begin
			cred_rng = xorshift32(cred_rng);
			for (int p = 0; p < NP; p++) begin
				if (!hold_cred[p] && owed[p] > 0 && cred_rng[p*2 +: 2] != 2'b00) begin
					resp_credit[p] = 1'b1;
					owed[p]--;
				end else begin
					resp_credit[p] = 1'b0;
				end
			end
		end
	end

	// ====================
	// Stimulus
	// ====================

	initial begin
		rng         = 32'd39;
		cred_rng    = xorshift32(xorshift32(32'd39));
		rst         = 1'b1;
		req         = '0;
		resp_credit = '0;
		for (int p = 0; p < NP; p++) begin
			req_cred[p] = 1;
			hold_cred[p] = 1'b0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		checking = 1'b1;

		// Quiet channel with no command
		repeat (12) begin
			@(posedge clk);
			check_value("resp.valid", resp.valid, 0);
			check_value("req_credit", req_credit, 0);
		end

		// Fill the whole array so every read has a known value
		for (int a = 0; a < DEPTH; a++)
			send_cmd(a % NP, mpmc_cmd_pkg::OP_WRITE, a, 0, (32'(a) * 32'h9e3779b1) ^ next_rand());
		wait_drain("array fill");

		// Write then single-beat read on each port
		for (int p = 0; p < NP; p++) begin
			send_cmd(p, mpmc_cmd_pkg::OP_WRITE, 32'(17 + p * 300), 0, next_rand());
			send_cmd(p, mpmc_cmd_pkg::OP_READ, 32'(17 + p * 300), 0, '0);
		end
		wait_drain("write then read");

		// Random bursts with one forced across the top of the address space
		send_cmd(0, mpmc_cmd_pkg::OP_READ, 32'(DEPTH - 3), 7, '0);
		for (int i = 0; i < 8; i++)
			send_cmd(next_rand() % NP, mpmc_cmd_pkg::OP_READ, next_rand() % DEPTH,
				next_rand() % 32, '0);
		wait_drain("random bursts");

		// Both ports compete for the sequencer
		fork
			send_reads(0, 6);
			send_reads(1, 6);
		join
		wait_drain("concurrent bursts");

		// Port 1 keeps its credits so only the initial ones can be spent
		hold_cred[1] = 1'b1;
		send_cmd(1, mpmc_cmd_pkg::OP_READ, 32'(DEPTH - 5), 11, '0);
		wait_ahead(1, `MPMC_RESP_CREDITS);
		repeat (24) @(negedge clk);
		check_value("beats ahead of credit", delivered[1] - returned[1], `MPMC_RESP_CREDITS);
		hold_cred[1] = 1'b0;
		wait_drain("credit-held burst");

		$display("errors: mismatches=%0d protocol=%0d timeouts=%0d",
			mismatches, protocol_errs, timeouts);
		if (mismatches + protocol_errs + timeouts == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
common/mpmc_cmd_pkg.sv
common/mpmc_ctrl_pkg.sv
source/mpmc_port_arbiter.sv
mpmc_engine/mpmc_state_machine.sv
mpmc_engine/mpmc_resp_burst_cnt.sv
source/mpmc_mem_array.sv
source/mpmc_top.sv
bench/mpmc_tb.sv

// File: Makefile
# Verilator build and run for the two-port burst memory controller

VERILATOR  ?= verilator
TOP        ?= mpmc_tb
RTL_TOP    ?= mpmc_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
BUILD_FLAGS ?= --assert -Wno-fatal
LINT_FLAGS ?= --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
